// ==== design/cc_geom_pkg.sv ====
// Default cache tag geometry; cc_tag_array and the testbench take their parameter defaults here.
package cc_geom_pkg;

  // associativity of each set.
  localparam int DEF_WAYS = 4;

  // set index width, 64 sets.
  localparam int DEF_SET_BITS = 6;

  // tag width; a line address is {tag, set}.
  localparam int DEF_TAG_BITS = 18;

endpackage

// ==== design/cc_op_pkg.sv ====
// Request opcodes and controller states of the tag array, imported by the controller and testbench.
package cc_op_pkg;

  // request operation carried on req_op.
  typedef enum logic [1:0] {
    OP_LOOKUP = 2'd0, // tag check only.
    OP_FILL   = 2'd1, // allocate the line unless present.
    OP_INVAL  = 2'd2  // drop the line if present.
  } cc_op_t;

  // controller state; init runs the clearing sweep.
  typedef enum logic {
    ST_INIT  = 1'b0,
    ST_READY = 1'b1
  } cc_state_t;

endpackage

// ==== design/cc_tag_ram.sv ====
// One-read one-write set memory with registered read and write-first bypass, typed by its entry.
`timescale 1ns/1ps

module cc_tag_ram #(
  parameter int  SET_BITS = cc_geom_pkg::DEF_SET_BITS,
  parameter type entry_t  = logic
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                rd_en,
  input  logic [SET_BITS-1:0] rd_set,
  output entry_t              rd_data,
  input  logic                wr_en,
  input  logic [SET_BITS-1:0] wr_set,
  input  entry_t              wr_data
);

  localparam int SETS = 1 << SET_BITS;

  entry_t mem [SETS];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_set] <= wr_data;
    end
  end

  // a read that meets a write to the same set takes the new entry.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_data <= '0;
    end else if (rd_en) begin
      if (wr_en && (wr_set == rd_set)) begin
        rd_data <= wr_data; // write-first.
      end else begin
        rd_data <= mem[rd_set];
      end
    end
  end

endmodule

// ==== design/cc_tag_way.sv ====
// One way of the tag array: stores valid, tag and even parity per set and compares on read.
`timescale 1ns/1ps

module cc_tag_way #(
  parameter int SET_BITS = cc_geom_pkg::DEF_SET_BITS,
  parameter int TAG_BITS = cc_geom_pkg::DEF_TAG_BITS
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                rd_en,
  input  logic [SET_BITS-1:0] rd_set,
  input  logic [TAG_BITS-1:0] cmp_tag,
  input  logic                wr_en,
  input  logic [SET_BITS-1:0] wr_set,
  input  logic [TAG_BITS-1:0] wr_tag,
  input  logic                wr_clear,
  output logic                hit,
  output logic                valid,
  output logic [TAG_BITS-1:0] tag,
  output logic                err
);

  // entry layout is {parity, valid, tag}.
  typedef logic [TAG_BITS+1:0] entry_t;

  entry_t              rd_entry;
  entry_t              wr_entry;
  logic [TAG_BITS:0]   wr_body;

  assign wr_body  = {1'b1, wr_tag};
  assign wr_entry = wr_clear ? '0 : {^wr_body, wr_body}; // all zero is even too.

  cc_tag_ram #(
    .SET_BITS (SET_BITS),
    .entry_t  (entry_t)
  ) ram_inst (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (rd_en),
    .rd_set  (rd_set),
    .rd_data (rd_entry),
    .wr_en   (wr_en),
    .wr_set  (wr_set),
    .wr_data (wr_entry)
  );

  assign valid = rd_entry[TAG_BITS];
  assign tag   = rd_entry[TAG_BITS-1:0];
  assign err   = ^rd_entry; // odd parity over the whole entry.
  assign hit   = valid && (tag == cmp_tag);

endmodule

// ==== design/cc_nru_ctrl.sv ====
// Per-set not-recently-used bits: applies the NRU update and picks the replacement way.
`timescale 1ns/1ps

module cc_nru_ctrl #(
  parameter int WAYS     = cc_geom_pkg::DEF_WAYS,
  parameter int SET_BITS = cc_geom_pkg::DEF_SET_BITS
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     rd_en,
  input  logic [SET_BITS-1:0]      rd_set,
  input  logic [WAYS-1:0]          valid_ways,
  input  logic                     upd_en,
  input  logic [$clog2(WAYS)-1:0]  upd_way,
  input  logic [SET_BITS-1:0]      upd_set,
  input  logic                     upd_clear,
  output logic [$clog2(WAYS)-1:0]  victim
);

  localparam int WAY_BITS = $clog2(WAYS);

  typedef logic [WAYS-1:0] nru_t;

  nru_t nru_rd;
  nru_t nru_set;
  nru_t nru_wr;

  cc_tag_ram #(
    .SET_BITS (SET_BITS),
    .entry_t  (nru_t)
  ) ram_inst (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (rd_en),
    .rd_set  (rd_set),
    .rd_data (nru_rd),
    .wr_en   (upd_en),
    .wr_set  (upd_set),
    .wr_data (nru_wr)
  );

  // mark the used way, restart the round when every bit would be set.
  always_comb begin
    nru_set = nru_rd;
    nru_set[upd_way] = 1'b1;
    if (&nru_set) begin
      nru_set = '0;
      nru_set[upd_way] = 1'b1;
    end
  end

  assign nru_wr = upd_clear ? '0 : nru_set;

  // invalid ways win over NRU choice, lowest index first.
  always_comb begin
    victim = '0;
    for (int i = WAYS - 1; i >= 0; i--) begin
      if (!nru_rd[i]) begin
        victim = WAY_BITS'(i);
      end
    end
    for (int i = WAYS - 1; i >= 0; i--) begin
      if (!valid_ways[i]) begin
        victim = WAY_BITS'(i);
      end
    end
  end

endmodule

// ==== design/cc_init_counter.sv ====
// Set counter for the post-reset clearing sweep; done marks the last set.
`timescale 1ns/1ps

module cc_init_counter #(
  parameter int SET_BITS = cc_geom_pkg::DEF_SET_BITS
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                en,
  output logic [SET_BITS-1:0] set_idx,
  output logic                done
);

  always_ff @(posedge clk) begin
    if (rst) begin
      set_idx <= '0;
    end else if (en) begin
      set_idx <= set_idx + 1'b1; // wraps to zero after the last set.
    end
  end

  assign done = en && (&set_idx);

endmodule

// ==== design/cc_tag_fsm.sv ====
// Tag array controller: init sweep, request staging, hit and victim resolution, writes and response.
`timescale 1ns/1ps

module cc_tag_fsm #(
  parameter int WAYS     = cc_geom_pkg::DEF_WAYS,
  parameter int SET_BITS = cc_geom_pkg::DEF_SET_BITS,
  parameter int TAG_BITS = cc_geom_pkg::DEF_TAG_BITS
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               req_valid,
  input  cc_op_pkg::cc_op_t                  req_op,
  input  logic [SET_BITS+TAG_BITS-1:0]       req_addr,
  input  logic [WAYS-1:0]                    way_hit,
  input  logic [WAYS-1:0]                    way_valid,
  input  logic [WAYS-1:0][TAG_BITS-1:0]      way_tag,
  input  logic [WAYS-1:0]                    way_err,
  input  logic [$clog2(WAYS)-1:0]            victim,
  input  logic                               init_done,
  input  logic [SET_BITS-1:0]                init_set,
  output logic                               busy,
  output logic                               init_en,
  output logic                               rd_en,
  output logic [SET_BITS-1:0]                rd_set,
  output logic [TAG_BITS-1:0]                cmp_tag,
  output logic [WAYS-1:0]                    wr_en,
  output logic [SET_BITS-1:0]                wr_set,
  output logic [TAG_BITS-1:0]                wr_tag,
  output logic                               wr_clear,
  output logic                               upd_en,
  output logic [$clog2(WAYS)-1:0]            upd_way,
  output logic                               upd_clear,
  output logic                               resp_valid,
  output logic                               resp_hit,
  output logic [$clog2(WAYS)-1:0]            resp_way,
  output logic                               resp_err,
  output logic                               evict_en,
  output logic [SET_BITS+TAG_BITS-1:0]       evict_addr
);

  import cc_op_pkg::*;

  localparam int WAY_BITS = $clog2(WAYS);

  cc_state_t           state;
  logic                stg_valid;
  cc_op_t              stg_op;
  logic [TAG_BITS-1:0] stg_tag;
  logic [SET_BITS-1:0] stg_set;
  logic                accept;
  logic                any_hit;
  logic [WAY_BITS-1:0] hit_way;
  logic                is_fill;
  logic                evict_c;
  logic [WAY_BITS-1:0] way_c;
  logic                err_c;

  assign busy    = (state == ST_INIT);
  assign init_en = busy;
  assign accept  = req_valid && !busy; // dropped silently while busy.

  assign rd_en   = accept;
  assign rd_set  = req_addr[SET_BITS-1:0];
  assign cmp_tag = stg_tag;
  assign wr_tag  = stg_tag;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_INIT;
      stg_valid <= 1'b0;
    end else begin
      if ((state == ST_INIT) && init_done) begin
        state <= ST_READY;
      end
      stg_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      stg_op  <= req_op;
      stg_set <= req_addr[SET_BITS-1:0];
      stg_tag <= req_addr[SET_BITS+TAG_BITS-1:SET_BITS];
    end
  end

  // lowest matching way.
  always_comb begin
    hit_way = '0;
    for (int i = WAYS - 1; i >= 0; i--) begin
      if (way_hit[i]) begin
        hit_way = WAY_BITS'(i);
      end
    end
  end

  assign any_hit = |way_hit;
  assign is_fill = (stg_op == OP_FILL);
  assign evict_c = stg_valid && is_fill && !any_hit && way_valid[victim];

  always_comb begin
    wr_en     = '0;
    wr_set    = stg_set;
    wr_clear  = 1'b0;
    upd_en    = 1'b0;
    upd_way   = hit_way;
    upd_clear = 1'b0;
    if (busy) begin
      wr_en     = '1; // sweep clears every way and the NRU bits.
      wr_set    = init_set;
      wr_clear  = 1'b1;
      upd_en    = 1'b1;
      upd_clear = 1'b1;
    end else if (stg_valid) begin
      case (stg_op)
        OP_LOOKUP: upd_en = any_hit;
        OP_FILL: begin
          upd_en = 1'b1;
          if (!any_hit) begin
            wr_en[victim] = 1'b1;
            upd_way       = victim;
          end
        end
        OP_INVAL: begin
          wr_en    = way_hit;
          wr_clear = 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign way_c = any_hit ? hit_way : (is_fill ? victim : '0);
  assign err_c = any_hit ? way_err[hit_way] : (is_fill && way_err[victim]);

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid <= 1'b0;
      resp_hit   <= 1'b0;
      resp_err   <= 1'b0;
      evict_en   <= 1'b0;
    end else begin
      resp_valid <= stg_valid;
      resp_hit   <= stg_valid && any_hit;
      resp_err   <= stg_valid && err_c;
      evict_en   <= evict_c;
    end
  end

  always_ff @(posedge clk) begin
    if (stg_valid) begin
      resp_way   <= way_c;
      evict_addr <= {way_tag[victim], stg_set}; // displaced line address.
    end
  end

endmodule

// ==== design/cc_tag_array.sv ====
// Top of the cache tag array; connects the ways, the NRU block, the sweep counter and the controller.
`timescale 1ns/1ps

module cc_tag_array #(
  parameter int WAYS     = cc_geom_pkg::DEF_WAYS,
  parameter int SET_BITS = cc_geom_pkg::DEF_SET_BITS,
  parameter int TAG_BITS = cc_geom_pkg::DEF_TAG_BITS
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          req_valid,
  input  cc_op_pkg::cc_op_t             req_op,
  input  logic [SET_BITS+TAG_BITS-1:0]  req_addr,
  output logic                          busy,
  output logic                          resp_valid,
  output logic                          resp_hit,
  output logic [$clog2(WAYS)-1:0]       resp_way,
  output logic                          resp_err,
  output logic                          evict_en,
  output logic [SET_BITS+TAG_BITS-1:0]  evict_addr
);

  localparam int WAY_BITS = $clog2(WAYS);

  logic                          rd_en;
  logic [SET_BITS-1:0]           rd_set;
  logic [TAG_BITS-1:0]           cmp_tag;
  logic [WAYS-1:0]               wr_en;
  logic [SET_BITS-1:0]           wr_set;
  logic [TAG_BITS-1:0]           wr_tag;
  logic                          wr_clear;
  logic [WAYS-1:0]               way_hit;
  logic [WAYS-1:0]               way_valid;
  logic [WAYS-1:0][TAG_BITS-1:0] way_tag;
  logic [WAYS-1:0]               way_err;
  logic                          upd_en;
  logic [WAY_BITS-1:0]           upd_way;
  logic                          upd_clear;
  logic [WAY_BITS-1:0]           victim;
  logic                          init_en;
  logic                          init_done;
  logic [SET_BITS-1:0]           init_set;

  for (genvar w = 0; w < WAYS; w++) begin : g_way
    cc_tag_way #(
      .SET_BITS (SET_BITS),
      .TAG_BITS (TAG_BITS)
    ) way_inst (
      .clk      (clk),
      .rst      (rst),
      .rd_en    (rd_en),
      .rd_set   (rd_set),
      .cmp_tag  (cmp_tag),
      .wr_en    (wr_en[w]),
      .wr_set   (wr_set),
      .wr_tag   (wr_tag),
      .wr_clear (wr_clear),
      .hit      (way_hit[w]),
      .valid    (way_valid[w]),
      .tag      (way_tag[w]),
      .err      (way_err[w])
    );
  end

  cc_nru_ctrl #(
    .WAYS     (WAYS),
    .SET_BITS (SET_BITS)
  ) nru_inst (
    .clk        (clk),
    .rst        (rst),
    .rd_en      (rd_en),
    .rd_set     (rd_set),
    .valid_ways (way_valid),
    .upd_en     (upd_en),
    .upd_way    (upd_way),
    .upd_set    (wr_set), // NRU follows the tag write set.
    .upd_clear  (upd_clear),
    .victim     (victim)
  );

  cc_init_counter #(
    .SET_BITS (SET_BITS)
  ) init_inst (
    .clk     (clk),
    .rst     (rst),
    .en      (init_en),
    .set_idx (init_set),
    .done    (init_done)
  );

  cc_tag_fsm #(
    .WAYS     (WAYS),
    .SET_BITS (SET_BITS),
    .TAG_BITS (TAG_BITS)
  ) fsm_inst (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_addr   (req_addr),
    .way_hit    (way_hit),
    .way_valid  (way_valid),
    .way_tag    (way_tag),
    .way_err    (way_err),
    .victim     (victim),
    .init_done  (init_done),
    .init_set   (init_set),
    .busy       (busy),
    .init_en    (init_en),
    .rd_en      (rd_en),
    .rd_set     (rd_set),
    .cmp_tag    (cmp_tag),
    .wr_en      (wr_en),
    .wr_set     (wr_set),
    .wr_tag     (wr_tag),
    .wr_clear   (wr_clear),
    .upd_en     (upd_en),
    .upd_way    (upd_way),
    .upd_clear  (upd_clear),
    .resp_valid (resp_valid),
    .resp_hit   (resp_hit),
    .resp_way   (resp_way),
    .resp_err   (resp_err),
    .evict_en   (evict_en),
    .evict_addr (evict_addr)
  );

endmodule

// ==== include/cc_tag_tb_table.svh ====
// Directed rows for the tag array testbench; included in the testbench module and run back to back.
// columns: op, tag, set, expected hit, expected way, expected evict_en, evicted tag.

localparam int DIR_ROWS = 25;

dir_row_t dir_table [DIR_ROWS];

task automatic load_dir_table();
  // set 9 fills its free ways in order.
  dir_table[0]  = make_row(OP_FILL,   18'h000a1, 9, 1'b0, 0, 1'b0, 18'h00000);
  dir_table[1]  = make_row(OP_LOOKUP, 18'h000a1, 9, 1'b1, 0, 1'b0, 18'h00000);
  dir_table[2]  = make_row(OP_FILL,   18'h000b2, 9, 1'b0, 1, 1'b0, 18'h00000);
  dir_table[3]  = make_row(OP_FILL,   18'h000c3, 9, 1'b0, 2, 1'b0, 18'h00000);
  dir_table[4]  = make_row(OP_FILL,   18'h000d4, 9, 1'b0, 3, 1'b0, 18'h00000); // nru restarts.
  // set is full, victims follow the NRU bits.
  dir_table[5]  = make_row(OP_FILL,   18'h000e5, 9, 1'b0, 0, 1'b1, 18'h000a1);
  dir_table[6]  = make_row(OP_LOOKUP, 18'h000a1, 9, 1'b0, 0, 1'b0, 18'h00000);
  dir_table[7]  = make_row(OP_FILL,   18'h000e5, 9, 1'b1, 0, 1'b0, 18'h00000);
  dir_table[8]  = make_row(OP_LOOKUP, 18'h000c3, 9, 1'b1, 2, 1'b0, 18'h00000);
  dir_table[9]  = make_row(OP_FILL,   18'h000f6, 9, 1'b0, 1, 1'b1, 18'h000b2);
  dir_table[10] = make_row(OP_FILL,   18'h00107, 9, 1'b0, 0, 1'b1, 18'h000e5);
  // invalidate frees a way that the next fill takes.
  dir_table[11] = make_row(OP_INVAL,  18'h000c3, 9, 1'b1, 2, 1'b0, 18'h00000);
  dir_table[12] = make_row(OP_LOOKUP, 18'h000c3, 9, 1'b0, 0, 1'b0, 18'h00000);
  dir_table[13] = make_row(OP_FILL,   18'h000a1, 9, 1'b0, 2, 1'b0, 18'h00000);
  dir_table[14] = make_row(OP_FILL,   18'h000b2, 9, 1'b0, 3, 1'b1, 18'h000d4);
  dir_table[15] = make_row(OP_LOOKUP, 18'h000d4, 9, 1'b0, 0, 1'b0, 18'h00000);
  dir_table[16] = make_row(OP_INVAL,  18'h000d4, 9, 1'b0, 0, 1'b0, 18'h00000);
  dir_table[17] = make_row(OP_LOOKUP, 18'h000b2, 9, 1'b1, 3, 1'b0, 18'h00000);
  dir_table[18] = make_row(OP_LOOKUP, 18'h00107, 9, 1'b1, 0, 1'b0, 18'h00000);
  // fill, drop and refill one line in set 10 on consecutive cycles.
  dir_table[19] = make_row(OP_FILL,   18'h000a1, 10, 1'b0, 0, 1'b0, 18'h00000);
  dir_table[20] = make_row(OP_INVAL,  18'h000a1, 10, 1'b1, 0, 1'b0, 18'h00000);
  dir_table[21] = make_row(OP_FILL,   18'h000a1, 10, 1'b0, 0, 1'b0, 18'h00000);
  dir_table[22] = make_row(OP_LOOKUP, 18'h000a1, 10, 1'b1, 0, 1'b0, 18'h00000);
  dir_table[23] = make_row(OP_LOOKUP, 18'h000a1, 9, 1'b1, 2, 1'b0, 18'h00000);
  dir_table[24] = make_row(OP_LOOKUP, 18'h000a1, 11, 1'b0, 0, 1'b0, 18'h00000);
endtask

// ==== sim/cc_tag_array_tb.sv ====
// Testbench for the cache tag array; runs the sweep, cold lookups, a directed table and a random run.
`timescale 1ns/1ps

module cc_tag_array_tb;

  import cc_geom_pkg::*;
  import cc_op_pkg::*;

  localparam int WAYS       = DEF_WAYS;
  localparam int SET_BITS   = DEF_SET_BITS;
  localparam int TAG_BITS   = DEF_TAG_BITS;
  localparam int ADDR_BITS  = SET_BITS + TAG_BITS;
  localparam int WAY_BITS   = $clog2(WAYS);
  localparam int SETS       = 1 << SET_BITS;
  localparam int RAND_COUNT = 240;
  localparam logic [TAG_BITS-1:0] DROP_TAG = '1;

  typedef struct packed {
    logic                 hit;
    logic [WAY_BITS-1:0]  way;
    logic                 chk_way; // way is only defined on a hit or a fill.
    logic                 evict;
    logic [ADDR_BITS-1:0] eaddr;
  } exp_t;

  typedef struct packed {
    cc_op_t               op;
    logic [ADDR_BITS-1:0] addr;
    exp_t                 e;
  } dir_row_t;

  logic                 clk;
  logic                 rst;
  logic                 req_valid;
  cc_op_t               req_op;
  logic [ADDR_BITS-1:0] req_addr;
  logic                 busy;
  logic                 resp_valid;
  logic                 resp_hit;
  logic [WAY_BITS-1:0]  resp_way;
  logic                 resp_err;
  logic                 evict_en;
  logic [ADDR_BITS-1:0] evict_addr;

  // reference state of the array.
  logic [TAG_BITS-1:0]  model_tag [SETS][WAYS];
  logic                 model_valid [SETS][WAYS];
  logic [WAYS-1:0]      model_nru [SETS];

  exp_t        exp_q [$];
  int          due_q [$];
  exp_t        mon_e;
  int          mon_due;
  logic [31:0] rng = 32'h7ac8;
  int          checks = 0;
  int          errors = 0;
  int          cycles = 0;

  cc_tag_array cc_tag_array_inst (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return {8'h00, rng[31:8]}; // low bits of an LCG repeat quickly.
  endfunction

  function automatic logic [ADDR_BITS-1:0] line_addr(input logic [TAG_BITS-1:0] tag,
                                                     input int set);
    return {tag, set[SET_BITS-1:0]};
  endfunction

  function automatic dir_row_t make_row(input cc_op_t op, input logic [TAG_BITS-1:0] tag,
                                        input int set, input logic hit, input int way,
                                        input logic evict, input logic [TAG_BITS-1:0] etag);
    dir_row_t row;
    row.op        = op;
    row.addr      = line_addr(tag, set);
    row.e.hit     = hit;
    row.e.way     = WAY_BITS'(way);
    row.e.chk_way = hit || (op == OP_FILL);
    row.e.evict   = evict;
    row.e.eaddr   = line_addr(etag, set);
    return row;
  endfunction

  `include "cc_tag_tb_table.svh"

  localparam int CYCLE_LIMIT = 2 * (2 * SETS + DIR_ROWS + RAND_COUNT) + 50;

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic mark_used(input int s, input int w);
    logic [WAYS-1:0] n;
    n = model_nru[s];
    n[w] = 1'b1;
    if (n == '1) begin
      n = '0; // a full round starts over with only this way marked.
      n[w] = 1'b1;
    end
    model_nru[s] = n;
  endtask

  function automatic int pick_victim(input int s);
    int v;
    v = -1;
    for (int w = 0; w < WAYS; w++) begin
      if (v < 0 && !model_valid[s][w]) v = w;
    end
    for (int w = 0; w < WAYS; w++) begin
      if (v < 0 && !model_nru[s][w]) v = w;
    end
    return (v < 0) ? 0 : v;
  endfunction

  task automatic predict_response(input cc_op_t op, input logic [ADDR_BITS-1:0] addr,
                                  output exp_t e);
    int                  s;
    int                  hw;
    int                  v;
    logic [TAG_BITS-1:0] t;
    s  = int'(addr[SET_BITS-1:0]);
    t  = addr[ADDR_BITS-1:SET_BITS];
    hw = -1;
    for (int w = 0; w < WAYS; w++) begin
      if (hw < 0 && model_valid[s][w] && model_tag[s][w] == t) hw = w;
    end
    e = '0;
    e.hit = (hw >= 0);
    e.chk_way = e.hit;
    if (e.hit) e.way = WAY_BITS'(hw);
    if (op == OP_FILL && !e.hit) begin
      v = pick_victim(s);
      e.way = WAY_BITS'(v);
      e.chk_way = 1'b1;
      e.evict = model_valid[s][v];
      e.eaddr = {model_tag[s][v], addr[SET_BITS-1:0]};
      model_valid[s][v] = 1'b1;
      model_tag[s][v] = t;
      mark_used(s, v);
    end else if (op == OP_INVAL && e.hit) begin
      model_valid[s][hw] = 1'b0;
    end else if (e.hit) begin
      mark_used(s, hw);
    end
  endtask

  task automatic send_request(input cc_op_t op, input logic [ADDR_BITS-1:0] addr,
                              input exp_t e);
    @(posedge clk);
    req_valid <= 1'b1;
    req_op    <= op;
    req_addr  <= addr;
    exp_q.push_back(e);
    due_q.push_back(cycles + 3); // accepted on the next edge, answered one edge later.
  endtask

  task automatic drain_responses();
    @(posedge clk);
    req_valid <= 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  task automatic report_test(input string name, input int start_err);
    $display("test %s finished, %0d errors", name, errors - start_err);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // responses are compared at the falling edge in request order.
  always @(negedge clk) begin
    if (!rst) begin
      if (evict_en && !resp_valid) begin
        errors++;
        $display("evict_en was high at %0t without a response", $time);
      end
      if (resp_valid && exp_q.size() == 0) begin
        errors++;
        $display("a response came at %0t with no request outstanding", $time);
      end else if (resp_valid) begin
        mon_e   = exp_q.pop_front();
        mon_due = due_q.pop_front();
        check("response cycle", cycles, mon_due);
        check("resp_hit", resp_hit, mon_e.hit);
        check("resp_err", resp_err, 1'b0);
        check("evict_en", evict_en, mon_e.evict);
        if (mon_e.chk_way) check("resp_way", resp_way, mon_e.way);
        if (mon_e.evict) check("evict_addr", evict_addr, mon_e.eaddr);
      end
    end
  end

  initial begin
    int                  start_err;
    int                  busy_cycles;
    logic [31:0]         r;
    cc_op_t              op;
    logic [TAG_BITS-1:0] tag;
    exp_t                e;
    rst       = 1'b1;
    req_valid = 1'b0;
    req_op    = OP_LOOKUP;
    req_addr  = '0;
    for (int s = 0; s < SETS; s++) begin
      model_nru[s] = '0;
      for (int w = 0; w < WAYS; w++) begin
        model_valid[s][w] = 1'b0;
        model_tag[s][w]   = '0;
      end
    end
    load_dir_table();
    repeat (3) @(posedge clk);
    rst       <= 1'b0;
    req_valid <= 1'b1; // arrives during the sweep and must be dropped.
    req_op    <= OP_FILL;
    req_addr  <= line_addr(DROP_TAG, 9);

    start_err   = errors;
    busy_cycles = 0;
    @(negedge clk);
    while (busy) begin
      busy_cycles++;
      check("resp_valid", resp_valid, 1'b0);
      check("evict_en", evict_en, 1'b0);
      @(posedge clk);
      req_valid <= 1'b0;
      @(negedge clk);
    end
    check("busy cycles", busy_cycles, SETS);
    report_test("sweep", start_err);

    start_err = errors;
    for (int s = 0; s < SETS; s++) begin
      send_request(OP_LOOKUP, line_addr(DROP_TAG, s), '0);
    end
    drain_responses();
    report_test("cold lookup", start_err);

    start_err = errors;
    for (int i = 0; i < DIR_ROWS; i++) begin
      predict_response(dir_table[i].op, dir_table[i].addr, e); // keeps the model in step.
      send_request(dir_table[i].op, dir_table[i].addr, dir_table[i].e);
    end
    drain_responses();
    report_test("directed", start_err);

    // four sets and six tags keep the sets full and lines coming back.
    start_err = errors;
    for (int i = 0; i < RAND_COUNT; i++) begin
      r = next_rand();
      if (r[2:0] == 3'd0) begin
        @(posedge clk);
        req_valid <= 1'b0;
      end else begin
        case (r[4:3])
          2'd0:    op = OP_LOOKUP;
          2'd3:    op = OP_INVAL;
          default: op = OP_FILL;
        endcase
        tag = TAG_BITS'(int'(r[15:8]) % 6 + 'h100);
        predict_response(op, line_addr(tag, 8 + int'(r[6:5])), e);
        send_request(op, line_addr(tag, 8 + int'(r[6:5])), e);
      end
    end
    drain_responses();
    report_test("random", start_err);

    $display("%0d checks run, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+include
design/cc_geom_pkg.sv
design/cc_op_pkg.sv
design/cc_tag_ram.sv
design/cc_tag_way.sv
design/cc_nru_ctrl.sv
design/cc_init_counter.sv
design/cc_tag_fsm.sv
design/cc_tag_array.sv
sim/cc_tag_array_tb.sv

// ==== Makefile ====
TOP := cc_tag_array_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f files.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
